//--- source/disk_pkg.sv
`default_nettype none

package disk_pkg;

    localparam int disk_banks      = 8;
    localparam int disk_bank_bits  = 3;
    localparam int disk_off_bits   = 13;
    localparam int disk_addr_bits  = 16;
    localparam int disk_size_bits  = 4;
    localparam int disk_line_bytes = 16;

    typedef struct packed {
        logic [disk_bank_bits-1:0] bank;
        logic [disk_off_bits-1:0]  off;
    } disk_bank_off_t;

    typedef union packed {
        logic [disk_addr_bits-1:0] flat;  // byte address.
        disk_bank_off_t            bo;    // bank in the top bits.
    } disk_addr_u;

    typedef struct packed {
        logic                      write;
        disk_addr_u                addr;
        logic [disk_size_bits-1:0] size;
        logic [7:0]                data;
    } disk_req_t;

    typedef struct packed {
        logic [disk_bank_bits-1:0] bank;
        logic [disk_off_bits-1:0]  off;
        logic [4:0]                len;   // zero when unused.
        logic [3:0]                base;  // first line position.
    } disk_seg_t;

    typedef struct packed {
        logic      valid;
        disk_seg_t seg0;
        disk_seg_t seg1;
        logic      split;
    } disk_plan_t;

    typedef struct packed {
        logic                      valid;
        logic [disk_bank_bits-1:0] bank;
        logic [disk_off_bits-1:0]  off;
        logic [3:0]                pos;
        logic                      last;
    } disk_rd_lane_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic [3:0] pos;
        logic       last;
    } disk_rd_byte_t;

    typedef struct packed {
        logic       valid;
        disk_addr_u addr;
        logic [7:0] data;
    } disk_wr_t;

endpackage

`default_nettype wire

//--- source/disk_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module disk_req_decode (
    input  wire                                clk,
    input  wire                                RST,
    input  wire                                en,
    input  wire                                we,
    input  wire disk_pkg::disk_addr_u          addr,
    input  wire [disk_pkg::disk_size_bits-1:0] size,
    input  wire [7:0]                          wdata,
    input  wire                                reader_idle,
    output logic                               busy,
    output disk_pkg::disk_wr_t                 wr,
    output disk_pkg::disk_plan_t               plan
);
    import disk_pkg::*;

    disk_req_t  req;
    logic       req_vld;
    logic       accept;
    disk_addr_u end_addr;
    logic       split;
    logic [4:0] len_all;
    logic [4:0] len0;

    assign accept = en && !busy;  // strobes while busy are dropped.

    always_ff @(posedge clk) begin
        if (RST) begin
            req_vld <= 1'b0;
            busy    <= 1'b0;
        end else begin
            req_vld <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (!plan.valid && reader_idle) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.write <= we;
            req.addr  <= addr;
            req.size  <= size;
            req.data  <= wdata;
        end
    end

    always_comb begin
        end_addr.flat = req.addr.flat + disk_addr_bits'(req.size);  // wraps at top.
        split         = end_addr.bo.bank != req.addr.bo.bank;
        len_all       = {1'b0, req.size} + 5'd1;
        // bytes left in the first bank when the read crosses it.
        len0          = split ? 5'(~req.addr.bo.off) + 5'd1 : len_all;

        plan.valid     = req_vld && !req.write;
        plan.split     = split;
        plan.seg0.bank = req.addr.bo.bank;
        plan.seg0.off  = req.addr.bo.off;
        plan.seg0.len  = len0;
        plan.seg0.base = 4'd0;
        plan.seg1.bank = req.addr.bo.bank + disk_bank_bits'(1);  // bank 7 wraps to 0.
        plan.seg1.off  = '0;
        plan.seg1.len  = len_all - len0;
        plan.seg1.base = len0[3:0];

        wr.valid = req_vld && req.write;
        wr.addr  = req.addr;
        wr.data  = req.data;
    end

    // a split segment 0 must end exactly on its bank boundary.
    a_seg_len_sum: assert property (@(posedge clk) disable iff (RST)
        plan.valid |-> (plan.seg0.len + plan.seg1.len == {1'b0, req.size} + 5'd1)
                       && (plan.split == (plan.seg1.len != 5'd0))
                       && (!plan.split
                           || ({1'b0, plan.seg0.off} + 14'(plan.seg0.len)
                               == 14'(2**disk_off_bits))));

endmodule

`default_nettype wire

//--- source/disk_seg_reader.sv
`timescale 1ns/1ps
`default_nettype none

module disk_seg_reader (
    input  wire                       clk,
    input  wire                       RST,
    input  wire disk_pkg::disk_plan_t plan,
    output disk_pkg::disk_rd_lane_t   lane0,
    output disk_pkg::disk_rd_lane_t   lane1,
    output logic                      reader_idle
);
    import disk_pkg::*;

    disk_seg_t     seg [2];
    disk_rd_lane_t lane_q [2];
    logic [4:0]    rem [2];  // issues still owed per lane.
    logic          final_issue;

    assign seg[0] = plan.seg0;
    assign seg[1] = plan.seg1;

    // last goes out when the longer lane makes its final read.
    always_comb begin
        if (plan.valid) begin
            final_issue = (plan.seg0.len <= 5'd1) && (plan.seg1.len <= 5'd1);
        end else begin
            final_issue = (rem[0] <= 5'd1) && (rem[1] <= 5'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (RST) begin
            for (int i = 0; i < 2; i++) begin
                lane_q[i].valid <= 1'b0;
                lane_q[i].last  <= 1'b0;
                rem[i]          <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (plan.valid) begin
                    lane_q[i].valid <= seg[i].len != 5'd0;
                    lane_q[i].bank  <= seg[i].bank;
                    lane_q[i].off   <= seg[i].off;
                    lane_q[i].pos   <= seg[i].base;
                    lane_q[i].last  <= final_issue && (seg[i].len != 5'd0);
                    rem[i]          <= (seg[i].len == 5'd0) ? 5'd0 : seg[i].len - 5'd1;
                end else if (rem[i] != 5'd0) begin
                    lane_q[i].valid <= 1'b1;
                    lane_q[i].off   <= lane_q[i].off + disk_off_bits'(1);
                    lane_q[i].pos   <= lane_q[i].pos + 4'd1;
                    lane_q[i].last  <= final_issue;
                    rem[i]          <= rem[i] - 5'd1;
                end else begin
                    lane_q[i].valid <= 1'b0;
                    lane_q[i].last  <= 1'b0;
                end
            end
        end
    end

    assign lane0       = lane_q[0];
    assign lane1       = lane_q[1];
    assign reader_idle = !lane_q[0].valid && !lane_q[1].valid;

    a_lane_bank_differ: assert property (@(posedge clk) disable iff (RST)
        lane0.valid && lane1.valid |-> lane0.bank != lane1.bank);

endmodule

`default_nettype wire

//--- source/disk_bank_array.sv
`timescale 1ns/1ps
`default_nettype none

module disk_bank_array (
    input  wire                          clk,
    input  wire disk_pkg::disk_wr_t      wr,
    input  wire disk_pkg::disk_rd_lane_t lane0,
    input  wire disk_pkg::disk_rd_lane_t lane1,
    output disk_pkg::disk_rd_byte_t      byte0,
    output disk_pkg::disk_rd_byte_t      byte1
);
    import disk_pkg::*;

    logic [7:0]    mem [disk_banks][2**disk_off_bits];
    disk_rd_lane_t lane [2];
    disk_rd_byte_t rd_q [2];

    initial begin
        for (int b = 0; b < disk_banks; b++) begin
            for (int a = 0; a < 2**disk_off_bits; a++) begin
                mem[b][a] = 8'h00;  // storage powers up empty.
            end
        end
    end

    always @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.addr.bo.bank][wr.addr.bo.off] <= wr.data;
        end
    end

    assign lane[0] = lane0;
    assign lane[1] = lane1;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            rd_q[i].valid <= lane[i].valid;
            rd_q[i].data  <= mem[lane[i].bank][lane[i].off];
            rd_q[i].pos   <= lane[i].pos;   // tag rides with the data.
            rd_q[i].last  <= lane[i].last;
        end
    end

    assign byte0 = rd_q[0];
    assign byte1 = rd_q[1];

endmodule

`default_nettype wire

//--- source/disk_line_assemble.sv
`timescale 1ns/1ps
`default_nettype none

module disk_line_assemble (
    input  wire                                    clk,
    input  wire                                    RST,
    input  wire disk_pkg::disk_rd_byte_t           byte0,
    input  wire disk_pkg::disk_rd_byte_t           byte1,
    output logic                                   done,
    output logic [disk_pkg::disk_line_bytes*8-1:0] data_out
);
    import disk_pkg::*;

    logic [disk_line_bytes*8-1:0] work;
    logic [disk_line_bytes*8-1:0] line_next;
    logic                         active;
    logic                         last;

    always_comb begin
        line_next = active ? work : '0;  // first byte starts a clean line.
        if (byte0.valid) begin
            line_next[8*byte0.pos +: 8] = byte0.data;
        end
        if (byte1.valid) begin
            line_next[8*byte1.pos +: 8] = byte1.data;
        end
        last = byte0.last || byte1.last;
    end

    always_ff @(posedge clk) begin
        if (RST) begin
            active   <= 1'b0;
            done     <= 1'b0;
            data_out <= '0;
        end else begin
            done <= last;
            if (last) begin
                active   <= 1'b0;
                data_out <= line_next;  // held until the next done.
            end else if (byte0.valid || byte1.valid) begin
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte0.valid || byte1.valid) begin
            work <= line_next;
        end
    end

    a_pos_differ: assert property (@(posedge clk) disable iff (RST)
        byte0.valid && byte1.valid |-> byte0.pos != byte1.pos);

endmodule

`default_nettype wire

//--- source/disk_top.sv
`timescale 1ns/1ps
`default_nettype none

module disk_top (
    input  wire                                    clk,
    input  wire                                    RST,
    input  wire                                    en,
    input  wire                                    we,
    input  wire disk_pkg::disk_addr_u              addr,
    input  wire [disk_pkg::disk_size_bits-1:0]     size,
    input  wire [7:0]                              wdata,
    output logic                                   busy,
    output logic                                   done,
    output logic [disk_pkg::disk_line_bytes*8-1:0] data_out
);
    import disk_pkg::*;

    disk_wr_t      wr;
    disk_plan_t    plan;
    disk_rd_lane_t lane0;
    disk_rd_lane_t lane1;
    disk_rd_byte_t byte0;
    disk_rd_byte_t byte1;
    logic          reader_idle;

    disk_req_decode i_decode (
        .clk         (clk),
        .RST         (RST),
        .en          (en),
        .we          (we),
        .addr        (addr),
        .size        (size),
        .wdata       (wdata),
        .reader_idle (reader_idle),
        .busy        (busy),
        .wr          (wr),
        .plan        (plan)
    );

    disk_seg_reader i_reader (
        .clk         (clk),
        .RST         (RST),
        .plan        (plan),
        .lane0       (lane0),
        .lane1       (lane1),
        .reader_idle (reader_idle)
    );

    disk_bank_array i_banks (
        .clk   (clk),
        .wr    (wr),
        .lane0 (lane0),
        .lane1 (lane1),
        .byte0 (byte0),
        .byte1 (byte1)
    );

    disk_line_assemble i_assemble (
        .clk      (clk),
        .RST      (RST),
        .byte0    (byte0),
        .byte1    (byte1),
        .done     (done),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

//--- verification/disk_tb.sv
`timescale 1ns/1ps
`default_nettype none

module disk_tb;
    import disk_pkg::*;

    localparam int n_writes     = 300;
    localparam int n_reads      = 120;
    localparam int n_split      = 80;
    localparam int n_strobe     = 60;
    localparam int n_pairs      = 40;
    localparam int n_ops        = 5 + n_writes + n_reads + n_split + n_strobe + 2 * n_pairs;
    localparam int reset_cycles = 10;
    localparam int cycle_limit  = 40 * n_ops + reset_cycles;

    logic                         clk;
    logic                         RST;
    logic                         en;
    logic                         we;
    disk_addr_u                   addr;
    logic [disk_size_bits-1:0]    size;
    logic [7:0]                   wdata;
    logic                         busy;
    logic                         done;
    logic [disk_line_bytes*8-1:0] data_out;

    logic [7:0]                   mem_model [2**disk_addr_bits];
    logic [31:0]                  lfsr;
    logic [disk_line_bytes*8-1:0] held_line;  // last line returned.
    int                           cycle_count;

    disk_top i_dut (
        .clk      (clk),
        .RST      (RST),
        .en       (en),
        .we       (we),
        .addr     (addr),
        .size     (size),
        .wdata    (wdata),
        .busy     (busy),
        .done     (done),
        .data_out (data_out)
    );

    always #50 clk = ~clk;

    // galois form, one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha3000000 : lfsr >> 1;
        end
        return v;
    endfunction

    // first or last 128 bytes of a random bank.
    function automatic logic [15:0] window_addr();
        logic [2:0] bank;
        logic       high;
        logic [6:0] low;
        bank = 3'(take_bits(3));
        high = 1'(take_bits(1));
        low  = 7'(take_bits(7));
        return {bank, high ? 6'h3f : 6'h00, low};
    endfunction

    function automatic logic [127:0] model_line(input logic [15:0] a, input logic [3:0] sz);
        logic [127:0] line;
        line = '0;
        for (int i = 0; i <= int'(sz); i++) begin
            line[8*i +: 8] = mem_model[a + 16'(i)];
        end
        return line;
    endfunction

    // accept to done is the longer segment plus two.
    function automatic int model_latency(input logic [15:0] a, input logic [3:0] sz);
        logic [15:0] last_a;
        int          len0;
        int          len1;
        last_a = a + 16'(sz);
        len0   = int'(sz) + 1;
        len1   = 0;
        if (last_a[15:13] != a[15:13]) begin
            len0 = (1 << disk_off_bits) - int'(a[12:0]);
            len1 = int'(sz) + 1 - len0;
        end
        return (len0 > len1 ? len0 : len1) + 2;
    endfunction

    task automatic check_line(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on the returned line");
        end
    endtask

    task automatic check_done_latency(input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] done latency got 'h%0h expected 'h%0h", got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on the read latency");
        end
    endtask

    task automatic check_busy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on a status level");
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic do_write(input logic [15:0] a, input logic [7:0] d);
        check_busy("busy", busy, 1'b0);
        en        = 1'b1;
        we        = 1'b1;
        addr.flat = a;
        wdata     = d;
        tick();
        en           = 1'b0;
        mem_model[a] = d;
        check_busy("busy", busy, 1'b1);
        check_line("data_out", data_out, held_line);
        tick();
        check_busy("busy", busy, 1'b0);  // one busy cycle per write.
    endtask

    task automatic do_read(input logic [15:0] a, input logic [3:0] sz, input bit noise);
        logic [127:0] exp_line;
        int           exp_lat;
        int           lat;
        exp_line = model_line(a, sz);
        exp_lat  = model_latency(a, sz);
        lat      = 0;
        check_busy("busy", busy, 1'b0);
        en        = 1'b1;
        we        = 1'b0;
        addr.flat = a;
        size      = sz;
        tick();
        en = 1'b0;
        check_busy("done", done, 1'b0);
        do begin
            check_busy("busy", busy, 1'b1);
            check_line("data_out", data_out, held_line);
            if (noise) begin
                en        = 1'(take_bits(1));  // must be dropped while busy.
                we        = 1'(take_bits(1));
                addr.flat = window_addr();
                size      = 4'(take_bits(4));
                wdata     = 8'(take_bits(8));
            end
            tick();
            lat++;
        end while (!done);
        en = 1'b0;
        check_busy("busy", busy, 1'b0);
        check_done_latency(lat, exp_lat);
        check_line("data_out", data_out, exp_line);
        held_line = exp_line;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [15:0] a;
        int          k;
        clk       = 1'b0;
        RST       = 1'b1;
        en        = 1'b0;
        we        = 1'b0;
        addr.flat = '0;
        size      = '0;
        wdata     = '0;
        lfsr      = 32'd32807;
        held_line = '0;
        mem_model = '{default: 8'h00};
        repeat (reset_cycles) @(posedge clk);
        #5;
        RST = 1'b0;
        check_busy("busy", busy, 1'b0);
        check_busy("done", done, 1'b0);
        check_line("data_out", data_out, '0);
        do_read(16'h1234, 4'hf, 1'b0);  // untouched memory.

        repeat (n_writes) do_write(window_addr(), 8'(take_bits(8)));
        repeat (n_reads) begin
            a        = window_addr();
            a[12:7]  = 6'h00;  // stays inside one bank.
            do_read(a, 4'(take_bits(4)), 1'b0);
        end

        repeat (n_split) begin
            k = int'(take_bits(4)) % 15;
            a = {3'(take_bits(3)), 13'((1 << disk_off_bits) - 1 - k)};
            do_read(a, 4'(k + 1 + int'(take_bits(4)) % (15 - k)), 1'b0);
        end
        do_write(16'hfffe, 8'ha5);
        do_write(16'h0001, 8'h5a);
        do_read(16'hfffa, 4'hf, 1'b0);  // bank 7 wraps to bank 0.

        repeat (n_strobe) do_read(window_addr(), 4'(take_bits(4)), 1'b1);
        repeat (n_pairs) begin
            a = window_addr();
            do_write(a, 8'(take_bits(8)));
            do_read(a, 4'(take_bits(4)), 1'b0);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/disk_pkg.sv
source/disk_req_decode.sv
source/disk_seg_reader.sv
source/disk_bank_array.sv
source/disk_line_assemble.sv
source/disk_top.sv
verification/disk_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= disk_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED
SOURCES   := $(wildcard source/*.sv verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
